// File: compile.f
+incdir+testbench
hw/tlb_pkg.sv
hw/tlb_issue.sv
hw/tlb_entry.sv
hw/tlb_result.sv
hw/tlb.sv
testbench/tlb_tb.sv

// File: testbench/tlb_ref.svh
`ifndef TLB_REF_SVH
`define TLB_REF_SVH

// outcome of one search, all fields zero on a miss
typedef struct packed {
    logic            found;
    logic [3:0]      index;
    tlb_pkg::pfn_t   pfn;
    tlb_pkg::cattr_t c;
    logic            d;
    logic            v;
} expect_t;

// one write as it appears on the DUT inputs
typedef struct packed {
    logic [3:0]      index;
    tlb_pkg::vpn2_t  vpn2;
    tlb_pkg::asid_t  asid;
    logic            g;
    tlb_pkg::pfn_t   pfn0;
    tlb_pkg::cattr_t c0;
    logic            d0;
    logic            v0;
    tlb_pkg::pfn_t   pfn1;
    tlb_pkg::cattr_t c1;
    logic            d1;
    logic            v1;
} write_t;

logic   m_present [16];
write_t m_entry   [16];

function automatic void model_clear();
    for (int i = 0; i < 16; i++) begin
        m_present[i] = 1'b0;
    end
endfunction

function automatic void model_write(write_t w);
    m_present[w.index] = 1'b1;
    m_entry[w.index]   = w;
endfunction

// match on vpn2, and on asid unless global
function automatic expect_t tlb_expect(tlb_pkg::vpn2_t vpn2, logic odd, tlb_pkg::asid_t asid);
    expect_t r;
    r = '0;
    for (int i = 0; i < 16; i++) begin
        if (m_present[i] && (m_entry[i].vpn2 == vpn2) &&
            (m_entry[i].g || (m_entry[i].asid == asid))) begin
            r.found = 1'b1;
            r.index = 4'(i);
            r.pfn   = odd ? m_entry[i].pfn1 : m_entry[i].pfn0;
            r.c     = odd ? m_entry[i].c1 : m_entry[i].c0;
            r.d     = odd ? m_entry[i].d1 : m_entry[i].d0;
            r.v     = odd ? m_entry[i].v1 : m_entry[i].v0;
        end
    end
    return r;
endfunction

`endif

// File: testbench/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;

    localparam int TLB_NUM = 16;
    localparam int IDX_W   = 4;
    localparam int TIMEOUT = 2000; // cycles

    logic aclk;
    logic reset;
    logic s0_valid, s0_odd_page, s1_valid, s1_odd_page;
    tlb_pkg::vpn2_t s0_vpn2, s1_vpn2, w_vpn2;
    tlb_pkg::asid_t s0_asid, s1_asid, w_asid;
    logic we, w_g, w_d0, w_v0, w_d1, w_v1;
    logic [IDX_W-1:0] w_index;
    tlb_pkg::pfn_t w_pfn0, w_pfn1;
    tlb_pkg::cattr_t w_c0, w_c1;
    logic s0_result_valid, s0_found, s0_d, s0_v;
    logic s1_result_valid, s1_found, s1_d, s1_v;
    logic [IDX_W-1:0] s0_index, s1_index;
    tlb_pkg::pfn_t s0_pfn, s1_pfn;
    tlb_pkg::cattr_t s0_c, s1_c;

    `include "tlb_ref.svh"

    typedef struct packed {
        expect_t exp;
        int      cyc;  // request edge
        int      test;
    } inflight_t;

    inflight_t      exp0_q [$];
    inflight_t      exp1_q [$];
    int             cycle = 0;
    int             test_id = 0;
    int             seed;
    logic           pend_we = 1'b0;
    write_t         pend;
    tlb_pkg::vpn2_t key_vpn2 [TLB_NUM]; // keys the stimulus has written
    tlb_pkg::asid_t key_asid [TLB_NUM];

    tlb #(.TLB_NUM(TLB_NUM)) tlb_i (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic string test_label(int id);
        case (id)
            1: return "reset_miss";
            2: return "write_then_search";
            3: return "asid_and_global";
            4: return "random_both_ports";
            5: return "rewrite_index";
            6: return "write_search_same_cycle";
            default: return "idle";
        endcase
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) fail_run("the run did not finish within the cycle limit");
    end

    function automatic inflight_t expect_now(tlb_pkg::vpn2_t vpn2, logic odd,
                                             tlb_pkg::asid_t asid);
        inflight_t f;
        f.exp  = tlb_expect(vpn2, odd, asid);
        f.cyc  = cycle;
        f.test = test_id;
        return f;
    endfunction

    // model follows the DUT inputs, a write lands one edge after it is sampled
    always @(posedge aclk) begin
        if (reset) begin
            model_clear();
            pend_we = 1'b0;
        end else begin
            if (pend_we) model_write(pend);
            if (s0_valid) exp0_q.push_back(expect_now(s0_vpn2, s0_odd_page, s0_asid));
            if (s1_valid) exp1_q.push_back(expect_now(s1_vpn2, s1_odd_page, s1_asid));
            pend_we = we;
            pend    = {w_index, w_vpn2, w_asid, w_g, w_pfn0, w_c0, w_d0, w_v0,
                       w_pfn1, w_c1, w_d1, w_v1};
        end
    end

    task automatic check_field(int test, int port, string field, logic [31:0] exp,
                               logic [31:0] act);
        assert (exp === act) else begin
            fail_run($sformatf("Error: %s port %0d %s expected %0h actual %0h",
                               test_label(test), port, field, exp, act));
        end
    endtask

    task automatic check_result(int port, inflight_t e, logic found, logic [IDX_W-1:0] index,
                                tlb_pkg::pfn_t pfn, tlb_pkg::cattr_t c, logic d, logic v);
        assert (cycle == e.cyc + 2) else begin
            fail_run($sformatf("port %0d result for the search of cycle %0d came at cycle %0d",
                               port, e.cyc, cycle));
        end
        check_field(e.test, port, "found", e.exp.found, found);
        check_field(e.test, port, "index", e.exp.index, index);
        check_field(e.test, port, "pfn", e.exp.pfn, pfn);
        check_field(e.test, port, "c", e.exp.c, c);
        check_field(e.test, port, "d", e.exp.d, d);
        check_field(e.test, port, "v", e.exp.v, v);
    endtask

    // outputs are stable mid-cycle
    always @(negedge aclk) begin
        if (s0_result_valid === 1'b1) begin
            if (exp0_q.size() == 0) fail_run("port 0 gave a result with no search outstanding");
            else check_result(0, exp0_q.pop_front(), s0_found, s0_index, s0_pfn, s0_c, s0_d,
                              s0_v);
        end
        if (s1_result_valid === 1'b1) begin
            if (exp1_q.size() == 0) fail_run("port 1 gave a result with no search outstanding");
            else check_result(1, exp1_q.pop_front(), s1_found, s1_index, s1_pfn, s1_c, s1_d,
                              s1_v);
        end
    end

    task automatic tick();
        @(posedge aclk);
        s0_valid <= 1'b0;
        s1_valid <= 1'b0;
        we       <= 1'b0;
    endtask

    task automatic start_test(int id);
        tick();
        test_id <= id;
    endtask

    task automatic set_search(int port, tlb_pkg::vpn2_t vpn2, logic odd, tlb_pkg::asid_t asid);
        if (port == 0) begin
            s0_valid    <= 1'b1;
            s0_vpn2     <= vpn2;
            s0_odd_page <= odd;
            s0_asid     <= asid;
        end else begin
            s1_valid    <= 1'b1;
            s1_vpn2     <= vpn2;
            s1_odd_page <= odd;
            s1_asid     <= asid;
        end
    endtask

    // low bits carry the index, so written vpn2 values never collide
    function automatic tlb_pkg::vpn2_t vpn2_for(int idx);
        return {15'($urandom), 4'(idx)};
    endfunction

    task automatic set_write(int idx, tlb_pkg::vpn2_t vpn2, tlb_pkg::asid_t asid, logic g);
        we            <= 1'b1;
        w_index       <= IDX_W'(idx);
        w_vpn2        <= vpn2;
        w_asid        <= asid;
        w_g           <= g;
        w_pfn0        <= tlb_pkg::pfn_t'($urandom);
        w_c0          <= tlb_pkg::cattr_t'($urandom);
        w_d0          <= 1'($urandom);
        w_v0          <= 1'($urandom);
        w_pfn1        <= tlb_pkg::pfn_t'($urandom);
        w_c1          <= tlb_pkg::cattr_t'($urandom);
        w_d1          <= 1'($urandom);
        w_v1          <= 1'($urandom);
        key_vpn2[idx] = vpn2;
        key_asid[idx] = asid;
    endtask

    task automatic random_search(int port);
        int idx;
        idx = $urandom_range(9, 0);
        if ($urandom_range(1, 0) == 1) begin
            set_search(port, key_vpn2[idx], 1'($urandom),
                       ($urandom_range(3, 0) == 0) ? tlb_pkg::asid_t'($urandom) : key_asid[idx]);
        end else begin
            set_search(port, tlb_pkg::vpn2_t'($urandom), 1'($urandom),
                       tlb_pkg::asid_t'($urandom));
        end
    endtask

    initial begin
        tlb_pkg::vpn2_t old_vpn2;
        seed = $urandom(99);
        reset = 1'b1;
        {s0_valid, s0_vpn2, s0_odd_page, s0_asid} = '0;
        {s1_valid, s1_vpn2, s1_odd_page, s1_asid} = '0;
        {we, w_index, w_vpn2, w_asid, w_g} = '0;
        {w_pfn0, w_c0, w_d0, w_v0, w_pfn1, w_c1, w_d1, w_v1} = '0;
        repeat (10) @(posedge aclk);
        reset <= 1'b0;

        start_test(1);
        repeat (5) tick(); // no pulse may show up while idle
        repeat (10) begin
            tick();
            random_search(0);
            random_search(1);
        end

        start_test(2);
        for (int i = 0; i < 8; i++) begin
            tick();
            set_write(i, vpn2_for(i), tlb_pkg::asid_t'($urandom), 1'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            tick();
            set_search(0, key_vpn2[i], 1'b0, key_asid[i]);
            set_search(1, key_vpn2[i], 1'b1, key_asid[i]);
            tick();
            set_search(0, key_vpn2[i], 1'b1, key_asid[i]);
            set_search(1, key_vpn2[i], 1'b0, key_asid[i]);
        end

        start_test(3);
        tick();
        set_write(8, vpn2_for(8), 8'h11, 1'b0);
        tick();
        set_write(9, vpn2_for(9), 8'h11, 1'b1);
        tick();
        set_search(0, key_vpn2[8], 1'b0, 8'h22); // miss, asid differs
        set_search(1, key_vpn2[9], 1'b1, 8'h22); // hit, global
        tick();
        set_search(0, key_vpn2[8], 1'b1, 8'h11);
        set_search(1, key_vpn2[9], 1'b0, 8'h11);

        start_test(4);
        repeat (200) begin
            tick();
            random_search(0);
            random_search(1);
        end

        start_test(5);
        old_vpn2 = key_vpn2[3];
        tick();
        set_write(3, vpn2_for(3), key_asid[3], 1'b0);
        tick();
        set_search(0, old_vpn2, 1'b0, key_asid[3]);
        set_search(1, key_vpn2[3], 1'b1, key_asid[3]);

        start_test(6);
        old_vpn2 = key_vpn2[5];
        tick();
        set_write(5, vpn2_for(5), key_asid[5], 1'b0);
        set_search(0, key_vpn2[5], 1'b0, key_asid[5]); // still the old contents
        set_search(1, old_vpn2, 1'b1, key_asid[5]);
        tick();
        set_search(0, key_vpn2[5], 1'b0, key_asid[5]);
        set_search(1, old_vpn2, 1'b1, key_asid[5]);

        repeat (4) tick();
        if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
            fail_run("some searches never returned a result");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: hw/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       s0_valid,
    input  tlb_pkg::vpn2_t             s0_vpn2,
    input  logic                       s0_odd_page,
    input  tlb_pkg::asid_t             s0_asid,
    input  logic                       s1_valid,
    input  tlb_pkg::vpn2_t             s1_vpn2,
    input  logic                       s1_odd_page,
    input  tlb_pkg::asid_t             s1_asid,
    input  logic                       we,
    input  logic [$clog2(TLB_NUM)-1:0] w_index,
    input  tlb_pkg::vpn2_t             w_vpn2,
    input  tlb_pkg::asid_t             w_asid,
    input  logic                       w_g,
    input  tlb_pkg::pfn_t              w_pfn0,
    input  tlb_pkg::cattr_t            w_c0,
    input  logic                       w_d0,
    input  logic                       w_v0,
    input  tlb_pkg::pfn_t              w_pfn1,
    input  tlb_pkg::cattr_t            w_c1,
    input  logic                       w_d1,
    input  logic                       w_v1,
    output logic                       s0_result_valid,
    output logic                       s0_found,
    output logic [$clog2(TLB_NUM)-1:0] s0_index,
    output tlb_pkg::pfn_t              s0_pfn,
    output tlb_pkg::cattr_t            s0_c,
    output logic                       s0_d,
    output logic                       s0_v,
    output logic                       s1_result_valid,
    output logic                       s1_found,
    output logic [$clog2(TLB_NUM)-1:0] s1_index,
    output tlb_pkg::pfn_t              s1_pfn,
    output tlb_pkg::cattr_t            s1_c,
    output logic                       s1_d,
    output logic                       s1_v
);

    // issue stage outputs
    logic               q_s0_valid;
    tlb_pkg::vpn2_t     q_s0_vpn2;
    logic               q_s0_odd_page;
    tlb_pkg::asid_t     q_s0_asid;
    logic               q_s1_valid;
    tlb_pkg::vpn2_t     q_s1_vpn2;
    logic               q_s1_odd_page;
    tlb_pkg::asid_t     q_s1_asid;
    logic [TLB_NUM-1:0] q_w_en;
    tlb_pkg::vpn2_t     q_w_vpn2;
    tlb_pkg::asid_t     q_w_asid;
    logic               q_w_g;
    tlb_pkg::pfn_t      q_w_pfn0;
    tlb_pkg::cattr_t    q_w_c0;
    logic               q_w_d0;
    logic               q_w_v0;
    tlb_pkg::pfn_t      q_w_pfn1;
    tlb_pkg::cattr_t    q_w_c1;
    logic               q_w_d1;
    logic               q_w_v1;

    // gathered per entry
    logic [TLB_NUM-1:0] hit0;
    logic [TLB_NUM-1:0] hit1;
    tlb_pkg::pfn_t      e_pfn0 [TLB_NUM];
    tlb_pkg::cattr_t    e_c0   [TLB_NUM];
    logic [TLB_NUM-1:0] e_d0;
    logic [TLB_NUM-1:0] e_v0;
    tlb_pkg::pfn_t      e_pfn1 [TLB_NUM];
    tlb_pkg::cattr_t    e_c1   [TLB_NUM];
    logic [TLB_NUM-1:0] e_d1;
    logic [TLB_NUM-1:0] e_v1;

    tlb_issue #(
        .TLB_NUM (TLB_NUM)
    ) tlb_issue_i (
        .aclk          (aclk),
        .reset         (reset),
        .s0_valid      (s0_valid),
        .s0_vpn2       (s0_vpn2),
        .s0_odd_page   (s0_odd_page),
        .s0_asid       (s0_asid),
        .s1_valid      (s1_valid),
        .s1_vpn2       (s1_vpn2),
        .s1_odd_page   (s1_odd_page),
        .s1_asid       (s1_asid),
        .we            (we),
        .w_index       (w_index),
        .w_vpn2        (w_vpn2),
        .w_asid        (w_asid),
        .w_g           (w_g),
        .w_pfn0        (w_pfn0),
        .w_c0          (w_c0),
        .w_d0          (w_d0),
        .w_v0          (w_v0),
        .w_pfn1        (w_pfn1),
        .w_c1          (w_c1),
        .w_d1          (w_d1),
        .w_v1          (w_v1),
        .q_s0_valid    (q_s0_valid),
        .q_s0_vpn2     (q_s0_vpn2),
        .q_s0_odd_page (q_s0_odd_page),
        .q_s0_asid     (q_s0_asid),
        .q_s1_valid    (q_s1_valid),
        .q_s1_vpn2     (q_s1_vpn2),
        .q_s1_odd_page (q_s1_odd_page),
        .q_s1_asid     (q_s1_asid),
        .q_w_en        (q_w_en),
        .q_w_vpn2      (q_w_vpn2),
        .q_w_asid      (q_w_asid),
        .q_w_g         (q_w_g),
        .q_w_pfn0      (q_w_pfn0),
        .q_w_c0        (q_w_c0),
        .q_w_d0        (q_w_d0),
        .q_w_v0        (q_w_v0),
        .q_w_pfn1      (q_w_pfn1),
        .q_w_c1        (q_w_c1),
        .q_w_d1        (q_w_d1),
        .q_w_v1        (q_w_v1)
    );

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_entry
        tlb_entry #(
            .TLB_NUM (TLB_NUM)
        ) tlb_entry_i (
            .aclk    (aclk),
            .reset   (reset),
            .w_en    (q_w_en[i]),
            .w_vpn2  (q_w_vpn2),
            .w_asid  (q_w_asid),
            .w_g     (q_w_g),
            .w_pfn0  (q_w_pfn0),
            .w_c0    (q_w_c0),
            .w_d0    (q_w_d0),
            .w_v0    (q_w_v0),
            .w_pfn1  (q_w_pfn1),
            .w_c1    (q_w_c1),
            .w_d1    (q_w_d1),
            .w_v1    (q_w_v1),
            .s0_vpn2 (q_s0_vpn2),
            .s0_asid (q_s0_asid),
            .s1_vpn2 (q_s1_vpn2),
            .s1_asid (q_s1_asid),
            .match0  (hit0[i]),
            .match1  (hit1[i]),
            .pfn0    (e_pfn0[i]),
            .c0      (e_c0[i]),
            .d0      (e_d0[i]),
            .v0      (e_v0[i]),
            .pfn1    (e_pfn1[i]),
            .c1      (e_c1[i]),
            .d1      (e_d1[i]),
            .v1      (e_v1[i])
        );
    end

    tlb_result #(
        .TLB_NUM (TLB_NUM)
    ) tlb_result_i (
        .aclk            (aclk),
        .reset           (reset),
        .hit0            (hit0),
        .hit1            (hit1),
        .e_pfn0          (e_pfn0),
        .e_c0            (e_c0),
        .e_d0            (e_d0),
        .e_v0            (e_v0),
        .e_pfn1          (e_pfn1),
        .e_c1            (e_c1),
        .e_d1            (e_d1),
        .e_v1            (e_v1),
        .q_s0_valid      (q_s0_valid),
        .q_s0_odd_page   (q_s0_odd_page),
        .q_s1_valid      (q_s1_valid),
        .q_s1_odd_page   (q_s1_odd_page),
        .s0_result_valid (s0_result_valid),
        .s0_found        (s0_found),
        .s0_index        (s0_index),
        .s0_pfn          (s0_pfn),
        .s0_c            (s0_c),
        .s0_d            (s0_d),
        .s0_v            (s0_v),
        .s1_result_valid (s1_result_valid),
        .s1_found        (s1_found),
        .s1_index        (s1_index),
        .s1_pfn          (s1_pfn),
        .s1_c            (s1_c),
        .s1_d            (s1_d),
        .s1_v            (s1_v)
    );

endmodule

// File: hw/tlb_result.sv
`timescale 1ns/1ps

module tlb_result #(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  logic                       aclk,
    input  logic                       reset,
    input  logic [TLB_NUM-1:0]         hit0,
    input  logic [TLB_NUM-1:0]         hit1,
    input  tlb_pkg::pfn_t              e_pfn0 [TLB_NUM],
    input  tlb_pkg::cattr_t            e_c0   [TLB_NUM],
    input  logic [TLB_NUM-1:0]         e_d0,
    input  logic [TLB_NUM-1:0]         e_v0,
    input  tlb_pkg::pfn_t              e_pfn1 [TLB_NUM],
    input  tlb_pkg::cattr_t            e_c1   [TLB_NUM],
    input  logic [TLB_NUM-1:0]         e_d1,
    input  logic [TLB_NUM-1:0]         e_v1,
    input  logic                       q_s0_valid,
    input  logic                       q_s0_odd_page,
    input  logic                       q_s1_valid,
    input  logic                       q_s1_odd_page,
    output logic                       s0_result_valid,
    output logic                       s0_found,
    output logic [$clog2(TLB_NUM)-1:0] s0_index,
    output tlb_pkg::pfn_t              s0_pfn,
    output tlb_pkg::cattr_t            s0_c,
    output logic                       s0_d,
    output logic                       s0_v,
    output logic                       s1_result_valid,
    output logic                       s1_found,
    output logic [$clog2(TLB_NUM)-1:0] s1_index,
    output tlb_pkg::pfn_t              s1_pfn,
    output tlb_pkg::cattr_t            s1_c,
    output logic                       s1_d,
    output logic                       s1_v
);

    localparam int IDX_W = $clog2(TLB_NUM);

    // both ports share one encoder, indexed by port
    logic [TLB_NUM-1:0] hit [2];
    logic               odd [2];
    logic               found_c [2];
    logic [IDX_W-1:0]   index_c [2];
    tlb_pkg::pfn_t      pfn_c [2];
    tlb_pkg::cattr_t    c_c [2];
    logic               d_c [2];
    logic               v_c [2];

    assign hit[0] = hit0;
    assign hit[1] = hit1;
    assign odd[0] = q_s0_odd_page;
    assign odd[1] = q_s1_odd_page;

    // and-or select, all zero on a miss
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            found_c[p] = |hit[p];
            index_c[p] = '0;
            pfn_c[p]   = '0;
            c_c[p]     = '0;
            d_c[p]     = 1'b0;
            v_c[p]     = 1'b0;
            for (int i = 0; i < TLB_NUM; i++) begin
                if (hit[p][i]) begin
                    index_c[p] = index_c[p] | IDX_W'(i);
                    pfn_c[p]   = pfn_c[p] | (odd[p] ? e_pfn1[i] : e_pfn0[i]);
                    c_c[p]     = c_c[p] | (odd[p] ? e_c1[i] : e_c0[i]);
                    d_c[p]     = d_c[p] | (odd[p] ? e_d1[i] : e_d0[i]);
                    v_c[p]     = v_c[p] | (odd[p] ? e_v1[i] : e_v0[i]);
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            s0_result_valid <= 1'b0;
            s1_result_valid <= 1'b0;
        end else begin
            s0_result_valid <= q_s0_valid; // one-cycle pulse
            s1_result_valid <= q_s1_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (q_s0_valid) begin
            s0_found <= found_c[0];
            s0_index <= index_c[0];
            s0_pfn   <= pfn_c[0];
            s0_c     <= c_c[0];
            s0_d     <= d_c[0];
            s0_v     <= v_c[0];
        end
        if (q_s1_valid) begin
            s1_found <= found_c[1];
            s1_index <= index_c[1];
            s1_pfn   <= pfn_c[1];
            s1_c     <= c_c[1];
            s1_d     <= d_c[1];
            s1_v     <= v_c[1];
        end
    end

    // overlapping entries would corrupt the or-encoded index
    a_hit0_onehot: assert property (
        @(posedge aclk) disable iff (reset) q_s0_valid |-> $onehot0(hit0)
    );
    a_hit1_onehot: assert property (
        @(posedge aclk) disable iff (reset) q_s1_valid |-> $onehot0(hit1)
    );

endmodule

// File: hw/tlb_entry.sv
`timescale 1ns/1ps

module tlb_entry #(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  logic            aclk,
    input  logic            reset,
    input  logic            w_en,
    input  tlb_pkg::vpn2_t  w_vpn2,
    input  tlb_pkg::asid_t  w_asid,
    input  logic            w_g,
    input  tlb_pkg::pfn_t   w_pfn0,
    input  tlb_pkg::cattr_t w_c0,
    input  logic            w_d0,
    input  logic            w_v0,
    input  tlb_pkg::pfn_t   w_pfn1,
    input  tlb_pkg::cattr_t w_c1,
    input  logic            w_d1,
    input  logic            w_v1,
    input  tlb_pkg::vpn2_t  s0_vpn2,
    input  tlb_pkg::asid_t  s0_asid,
    input  tlb_pkg::vpn2_t  s1_vpn2,
    input  tlb_pkg::asid_t  s1_asid,
    output logic            match0,
    output logic            match1,
    output tlb_pkg::pfn_t   pfn0,
    output tlb_pkg::cattr_t c0,
    output logic            d0,
    output logic            v0,
    output tlb_pkg::pfn_t   pfn1,
    output tlb_pkg::cattr_t c1,
    output logic            d1,
    output logic            v1
);

    logic           present; // set by the first write after reset
    tlb_pkg::vpn2_t vpn2;
    tlb_pkg::asid_t asid;
    logic           g;

    always_ff @(posedge aclk) begin
        if (reset) begin
            present <= 1'b0;
        end else if (w_en) begin
            present <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (w_en) begin
            vpn2 <= w_vpn2;
            asid <= w_asid;
            g    <= w_g;
            pfn0 <= w_pfn0; // even page
            c0   <= w_c0;
            d0   <= w_d0;
            v0   <= w_v0;
            pfn1 <= w_pfn1; // odd page
            c1   <= w_c1;
            d1   <= w_d1;
            v1   <= w_v1;
        end
    end

    // global entries ignore the asid
    assign match0 = present && (vpn2 == s0_vpn2) && (g || (asid == s0_asid));
    assign match1 = present && (vpn2 == s1_vpn2) && (g || (asid == s1_asid));

endmodule

// File: hw/tlb_issue.sv
`timescale 1ns/1ps

module tlb_issue #(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM_DEFAULT
) (
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       s0_valid,
    input  tlb_pkg::vpn2_t             s0_vpn2,
    input  logic                       s0_odd_page,
    input  tlb_pkg::asid_t             s0_asid,
    input  logic                       s1_valid,
    input  tlb_pkg::vpn2_t             s1_vpn2,
    input  logic                       s1_odd_page,
    input  tlb_pkg::asid_t             s1_asid,
    input  logic                       we,
    input  logic [$clog2(TLB_NUM)-1:0] w_index,
    input  tlb_pkg::vpn2_t             w_vpn2,
    input  tlb_pkg::asid_t             w_asid,
    input  logic                       w_g,
    input  tlb_pkg::pfn_t              w_pfn0,
    input  tlb_pkg::cattr_t            w_c0,
    input  logic                       w_d0,
    input  logic                       w_v0,
    input  tlb_pkg::pfn_t              w_pfn1,
    input  tlb_pkg::cattr_t            w_c1,
    input  logic                       w_d1,
    input  logic                       w_v1,
    output logic                       q_s0_valid,
    output tlb_pkg::vpn2_t             q_s0_vpn2,
    output logic                       q_s0_odd_page,
    output tlb_pkg::asid_t             q_s0_asid,
    output logic                       q_s1_valid,
    output tlb_pkg::vpn2_t             q_s1_vpn2,
    output logic                       q_s1_odd_page,
    output tlb_pkg::asid_t             q_s1_asid,
    output logic [TLB_NUM-1:0]         q_w_en,
    output tlb_pkg::vpn2_t             q_w_vpn2,
    output tlb_pkg::asid_t             q_w_asid,
    output logic                       q_w_g,
    output tlb_pkg::pfn_t              q_w_pfn0,
    output tlb_pkg::cattr_t            q_w_c0,
    output logic                       q_w_d0,
    output logic                       q_w_v0,
    output tlb_pkg::pfn_t              q_w_pfn1,
    output tlb_pkg::cattr_t            q_w_c1,
    output logic                       q_w_d1,
    output logic                       q_w_v1
);

    localparam int IDX_W = $clog2(TLB_NUM);

    logic [TLB_NUM-1:0] w_dec; // one-hot of w_index

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            w_dec[i] = (w_index == IDX_W'(i));
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            q_s0_valid <= 1'b0;
            q_s1_valid <= 1'b0;
            q_w_en     <= '0;
        end else begin
            q_s0_valid <= s0_valid;
            q_s1_valid <= s1_valid;
            q_w_en     <= we ? w_dec : '0;
        end
    end

    // search keys and write payload
    always_ff @(posedge aclk) begin
        q_s0_vpn2     <= s0_vpn2;
        q_s0_odd_page <= s0_odd_page;
        q_s0_asid     <= s0_asid;
        q_s1_vpn2     <= s1_vpn2;
        q_s1_odd_page <= s1_odd_page;
        q_s1_asid     <= s1_asid;
        q_w_vpn2      <= w_vpn2;
        q_w_asid      <= w_asid;
        q_w_g         <= w_g;
        q_w_pfn0      <= w_pfn0;
        q_w_c0        <= w_c0;
        q_w_d0        <= w_d0;
        q_w_v0        <= w_v0;
        q_w_pfn1      <= w_pfn1;
        q_w_c1        <= w_c1;
        q_w_d1        <= w_d1;
        q_w_v1        <= w_v1;
    end

    // a write must name a known entry
    a_w_index_known: assert property (
        @(posedge aclk) disable iff (reset) we |-> !$isunknown(w_index)
    );

endmodule

// File: hw/tlb_pkg.sv
package tlb_pkg;

    // virtual page pair number, va[31:13]
    // one entry maps an even page and the odd page after it
    typedef logic [18:0] vpn2_t;

    // address space id, compared unless the entry is global
    typedef logic [7:0] asid_t;

    // physical frame number, pa[31:12]
    typedef logic [19:0] pfn_t;

    // cache attribute of a page
    typedef logic [2:0] cattr_t;

    // entry count when the top level is left at its default
    // the design works for any power of two from 2 to 64
    parameter int TLB_NUM_DEFAULT = 16;

endpackage
